// File: common/alu_pkg.sv
package alu_pkg;

   // datapath width.
   localparam int data_w = 64;

   // the adder computes a real carry only at every sparse_k-th bit.
   localparam int sparse_k = 4;

   // opcodes accepted on the req/ack port.
   typedef enum logic [2:0] {
      op_add = 3'd0,
      op_sub = 3'd1,
      op_and = 3'd2,
      op_or  = 3'd3,
      op_xor = 3'd4
   } alu_op_e;

   // four-phase port controller.
   typedef enum logic [1:0] {
      st_idle = 2'd0,  // waiting for req.
      st_busy = 2'd1,  // operands held, datapath settling.
      st_done = 2'd2   // ack high until req drops.
   } ctrl_state_e;

endpackage

// File: adder/sparse_carry_adder.sv
`timescale 1ns/10ps

module sparse_carry_adder (
   input  logic [alu_pkg::data_w-1:0] a,
   input  logic [alu_pkg::data_w-1:0] b,
   input  logic                       cin,
   output logic [alu_pkg::data_w-1:0] sum,
   output logic                       cout
);
   import alu_pkg::*;

   localparam int n_pair = data_w / 2;
   localparam int n_grp  = data_w / sparse_k;

   // index 0 holds cin as a generate, bit i of a and b sits at index i+1.
   logic [data_w:0]   p_x;
   logic [data_w:0]   g_x;

   logic [n_pair-1:0] gp1;  // pair generate.
   logic [n_pair-1:0] pp1;  // pair propagate.
   logic [n_grp-1:0]  gg;   // group of four generate.
   logic [n_grp-1:0]  pg;   // group of four propagate.

   logic [n_grp:0]    c_grp;  // carry into index sparse_k*k.
   logic [n_grp-1:0]  c_mid;  // carry into the middle of each group.
   logic [data_w:1]   cx;     // carry into every index.

   assign p_x = {a ^ b, 1'b0};
   assign g_x = {a & b, cin};

   genvar i;

   // first prefix level, adjacent pairs.
   generate
      for (i = 0; i < n_pair; i++) begin : g_lvl1
         assign gp1[i] = g_x[2*i+1] | p_x[2*i+1] & g_x[2*i];
         assign pp1[i] = p_x[2*i+1] & p_x[2*i];
      end
   endgenerate

   // second prefix level, pairs of pairs.
   generate
      for (i = 0; i < n_grp; i++) begin : g_lvl2
         assign gg[i] = gp1[2*i+1] | pp1[2*i+1] & gp1[2*i];
         assign pg[i] = pp1[2*i+1] & pp1[2*i];
      end
   endgenerate

   // group 0 already folds in cin through g_x[0].
   always_comb begin
      c_grp[0] = 1'b0;
      for (int k = 0; k < n_grp; k++) begin
         c_grp[k+1] = gg[k] | pg[k] & c_grp[k];
      end
   end

   // local fill inside each group from its incoming sparse carry.
   generate
      for (i = 0; i < n_grp; i++) begin : g_fill
         assign c_mid[i] = gp1[2*i] | pp1[2*i] & c_grp[i];

         assign cx[sparse_k*i+1] = g_x[sparse_k*i] | p_x[sparse_k*i] & c_grp[i];
         assign cx[sparse_k*i+2] = c_mid[i];
         assign cx[sparse_k*i+3] = g_x[sparse_k*i+2] | p_x[sparse_k*i+2] & c_mid[i];
      end
   endgenerate

   // group boundaries take the chained carry directly.
   generate
      for (i = 1; i <= n_grp; i++) begin : g_tap
         assign cx[sparse_k*i] = c_grp[i];
      end
   endgenerate

   assign sum  = p_x[data_w:1] ^ cx;
   assign cout = g_x[data_w] | p_x[data_w] & cx[data_w];  // out of the msb.

endmodule

// File: hw/logic_unit.sv
`timescale 1ns/10ps

module logic_unit (
   input  alu_pkg::alu_op_e            op,
   input  logic [alu_pkg::data_w-1:0]  a,
   input  logic [alu_pkg::data_w-1:0]  b,
   output logic [alu_pkg::data_w-1:0]  logic_res
);
   import alu_pkg::*;

   // operands arrive already registered by the port controller.
   always_comb begin
      case (op)
         op_and:  logic_res = a & b;
         op_or:   logic_res = a | b;
         op_xor:  logic_res = a ^ b;
         default: logic_res = '0;  // add and sub go through the adder.
      endcase
   end

endmodule

// File: hw/result_merge.sv
`timescale 1ns/10ps

module result_merge (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        load,
   input  alu_pkg::alu_op_e            op,
   input  logic [alu_pkg::data_w-1:0]  a,
   input  logic [alu_pkg::data_w-1:0]  b,
   input  logic [alu_pkg::data_w-1:0]  sum,
   input  logic [alu_pkg::data_w-1:0]  logic_res,
   input  logic                        cout,
   output logic [alu_pkg::data_w-1:0]  result,
   output logic                        zero,
   output logic                        negative,
   output logic                        carry,
   output logic                        overflow
);
   import alu_pkg::*;

   localparam int msb = data_w - 1;

   logic              is_sub;
   logic              is_arith;
   logic [data_w-1:0] sel;
   logic              sign_flip;  // result sign differs from a.
   logic              ovf;

   assign is_sub    = (op == op_sub);
   assign is_arith  = (op == op_add) || is_sub;
   assign sel       = is_arith ? sum : logic_res;
   assign sign_flip = sum[msb] ^ a[msb];

   // b here is the true operand, not the inverted adder input.
   assign ovf = is_sub ? ((a[msb] ^ b[msb]) & sign_flip)
                       : (~(a[msb] ^ b[msb]) & sign_flip);

   always_ff @(posedge clk) begin
      if (rst) begin
         result   <= '0;
         zero     <= 1'b0;
         negative <= 1'b0;
         carry    <= 1'b0;
         overflow <= 1'b0;
      end else if (load) begin
         result   <= sel;
         zero     <= (sel == '0);
         negative <= sel[msb];
         carry    <= is_arith & cout;  // no borrow on sub.
         overflow <= is_arith & ovf;
      end
   end

   a_logic_flags: assert property (@(posedge clk) disable iff (rst)
      load && !is_arith |=> !carry && !overflow)
      else $error("carry or overflow set after a logic op");

endmodule

// File: hw/op_port_ctrl.sv
`timescale 1ns/10ps

module op_port_ctrl (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req,
   input  alu_pkg::alu_op_e            op,
   input  logic [alu_pkg::data_w-1:0]  a,
   input  logic [alu_pkg::data_w-1:0]  b,
   output logic                        ack,
   output logic                        load,
   output alu_pkg::alu_op_e            op_q,
   output logic [alu_pkg::data_w-1:0]  a_q,
   output logic [alu_pkg::data_w-1:0]  b_q,
   output logic [alu_pkg::data_w-1:0]  add_b,
   output logic                        add_cin
);
   import alu_pkg::*;

   ctrl_state_e state;
   logic        take;

   assign take = (state == st_idle) && req;  // new request accepted.

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         ack   <= 1'b0;
         load  <= 1'b0;
      end else begin
         load <= 1'b0;
         case (state)
            st_idle: begin
               if (take) begin
                  state <= st_busy;
                  load  <= 1'b1;  // merge registers on the next edge.
               end
            end
            st_busy: begin
               state <= st_done;
               ack   <= 1'b1;
            end
            st_done: begin
               if (!req) begin
                  state <= st_idle;
                  ack   <= 1'b0;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // subtract becomes a + ~b + 1, so the adder needs no opcode.
   always_ff @(posedge clk) begin
      if (take) begin
         op_q    <= op;
         a_q     <= a;
         b_q     <= b;
         add_b   <= (op == op_sub) ? ~b : b;
         add_cin <= (op == op_sub);
      end
   end

   a_idle_no_ack: assert property (@(posedge clk) disable iff (rst)
      state == st_idle |-> !ack)
      else $error("ack high while idle");

   a_ops_hold: assert property (@(posedge clk) disable iff (rst)
      ack |=> !ack || ($stable(op_q) && $stable(a_q) && $stable(b_q)))
      else $error("captured operands moved while ack high");

endmodule

// File: hw/alu_top.sv
`timescale 1ns/10ps

module alu_top (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req,
   input  alu_pkg::alu_op_e            op,
   input  logic [alu_pkg::data_w-1:0]  a,
   input  logic [alu_pkg::data_w-1:0]  b,
   output logic                        ack,
   output logic [alu_pkg::data_w-1:0]  result,
   output logic                        zero,
   output logic                        negative,
   output logic                        carry,
   output logic                        overflow
);
   import alu_pkg::*;

   alu_op_e           op_q;
   logic [data_w-1:0] a_q;
   logic [data_w-1:0] b_q;
   logic [data_w-1:0] add_b;
   logic              add_cin;
   logic              load;
   logic [data_w-1:0] sum;
   logic              cout;
   logic [data_w-1:0] logic_res;

   op_port_ctrl u_ctrl (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .op      (op),
      .a       (a),
      .b       (b),
      .ack     (ack),
      .load    (load),
      .op_q    (op_q),
      .a_q     (a_q),
      .b_q     (b_q),
      .add_b   (add_b),
      .add_cin (add_cin)
   );

   sparse_carry_adder u_add (
      .a    (a_q),
      .b    (add_b),
      .cin  (add_cin),
      .sum  (sum),
      .cout (cout)
   );

   logic_unit u_logic (
      .op        (op_q),
      .a         (a_q),
      .b         (b_q),
      .logic_res (logic_res)
   );

   result_merge u_merge (
      .clk       (clk),
      .rst       (rst),
      .load      (load),
      .op        (op_q),
      .a         (a_q),
      .b         (b_q),
      .sum       (sum),
      .logic_res (logic_res),
      .cout      (cout),
      .result    (result),
      .zero      (zero),
      .negative  (negative),
      .carry     (carry),
      .overflow  (overflow)
   );

endmodule

// File: bench/alu_tb.sv
`timescale 1ns/10ps

module alu_tb;
   import alu_pkg::*;

   localparam int msb      = data_w - 1;
   localparam int max_wait = 50;  // edges before a wait gives up.
   localparam int seed     = 50808;

   logic              clk;
   logic              rst;
   logic              req;
   alu_op_e           op;
   logic [data_w-1:0] a;
   logic [data_w-1:0] b;
   logic              ack;
   logic [data_w-1:0] result;
   logic              zero;
   logic              negative;
   logic              carry;
   logic              overflow;

   // model outputs for the operation in flight.
   logic [data_w-1:0] exp_result;
   logic              exp_zero;
   logic              exp_negative;
   logic              exp_carry;
   logic              exp_overflow;

   int fails;
   int ops;
   int fails_before;

   alu_top DUT (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .op       (op),
      .a        (a),
      .b        (b),
      .ack      (ack),
      .result   (result),
      .zero     (zero),
      .negative (negative),
      .carry    (carry),
      .overflow (overflow)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   a_reset_clear: assert property (@(posedge clk)
      $fell(rst) |-> !ack && result == '0 && !zero && !negative && !carry && !overflow)
      else begin
         fails++;
         $display("[FAIL] %0t ack or outputs not clear after reset", $time);
      end

   a_result: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> result == exp_result && zero == exp_zero && negative == exp_negative
                     && carry == exp_carry && overflow == exp_overflow)
      else begin
         fails++;
         $display("[FAIL] %0t got %h zncv %b%b%b%b, expected %h zncv %b%b%b%b", $time,
                  result, zero, negative, carry, overflow,
                  exp_result, exp_zero, exp_negative, exp_carry, exp_overflow);
      end

   // req first sampled two edges before ack shows high.
   a_ack_latency: assert property (@(posedge clk) disable iff (rst)
      $rose(ack) |-> $past(req, 2) && !$past(req, 3))
      else begin
         fails++;
         $display("[FAIL] %0t ack did not rise two edges after req", $time);
      end

   a_hold: assert property (@(posedge clk) disable iff (rst)
      ack && req |=> ack && $stable(result) && $stable(zero) && $stable(negative)
                     && $stable(carry) && $stable(overflow))
      else begin
         fails++;
         $display("[FAIL] %0t ack or outputs moved while req held", $time);
      end

   a_release: assert property (@(posedge clk) disable iff (rst)
      ack && !req |=> !ack)
      else begin
         fails++;
         $display("[FAIL] %0t ack still high one edge after req low", $time);
      end

   function automatic logic [data_w-1:0] rand_word();
      return {$urandom(), $urandom()};
   endfunction

   function automatic alu_op_e pick_op(input int unsigned sel);
      case (sel)
         0:       return op_add;
         1:       return op_sub;
         2:       return op_and;
         3:       return op_or;
         default: return op_xor;
      endcase
   endfunction

   // reference rules: carry is the 65th bit, or no-borrow for sub.
   task automatic model_result(input alu_op_e o, input logic [data_w-1:0] x,
                               input logic [data_w-1:0] y);
      logic [data_w:0]   wide;
      logic [data_w-1:0] r;
      logic              c;
      logic              v;
      c = 1'b0;
      v = 1'b0;
      case (o)
         op_add: begin
            wide = {1'b0, x} + {1'b0, y};
            r    = wide[data_w-1:0];
            c    = wide[data_w];
            v    = (x[msb] == y[msb]) && (r[msb] != x[msb]);
         end
         op_sub: begin
            r = x - y;
            c = (x >= y);
            v = (x[msb] != y[msb]) && (r[msb] != x[msb]);
         end
         op_and:  r = x & y;
         op_or:   r = x | y;
         default: r = x ^ y;
      endcase
      exp_result   = r;
      exp_zero     = (r == '0);
      exp_negative = r[msb];
      exp_carry    = c;
      exp_overflow = v;
   endtask

   // one full four-phase transfer, req kept up for hold extra cycles.
   task automatic issue_op(input alu_op_e o, input logic [data_w-1:0] x,
                           input logic [data_w-1:0] y, input int hold);
      int n;
      @(negedge clk);
      op  = o;
      a   = x;
      b   = y;
      model_result(o, x, y);
      req = 1'b1;
      n = 0;
      while (!ack && n < max_wait) begin
         @(negedge clk);
         n++;
      end
      if (!ack) begin
         fails++;
         $display("timeout at %0t: no ack for %s", $time, o.name());
      end
      repeat (hold) @(negedge clk);
      req = 1'b0;
      n = 0;
      while (ack && n < max_wait) begin
         @(negedge clk);
         n++;
      end
      if (ack) begin
         fails++;
         $display("timeout at %0t: ack never dropped after req went low", $time);
      end
      ops++;
   endtask

   task automatic report_test(input string name);
      $display("%s done, %0d failures", name, fails - fails_before);
      fails_before = fails;
   endtask

   task automatic add_random();
      for (int i = 0; i < 40; i++) begin
         issue_op(op_add, rand_word(), rand_word(), 0);
      end
      report_test("add_random");
   endtask

   task automatic sub_random();
      logic [data_w-1:0] x;
      for (int i = 0; i < 40; i++) begin
         issue_op(op_sub, rand_word(), rand_word(), 0);
      end
      x = rand_word();
      issue_op(op_sub, x, x, 0);  // equal operands give zero.
      issue_op(op_sub, '0, '0, 0);
      issue_op(op_sub, 64'd5, 64'd9, 0);
      issue_op(op_sub, '0, 64'd1, 0);
      issue_op(op_sub, x >> 1, x | 64'h8000_0000_0000_0000, 0);
      report_test("sub_random");
   endtask

   task automatic carry_edges();
      logic [data_w-1:0] ones_low;
      issue_op(op_add, '1, 64'd1, 0);
      for (int k = 1; k < data_w / sparse_k; k++) begin
         ones_low = (64'd1 << (sparse_k * k)) - 64'd1;
         issue_op(op_add, ones_low, 64'd1, 0);  // ripple into the next group.
         issue_op(op_add, 64'd1, ones_low, 0);
      end
      issue_op(op_add, 64'h7fff_ffff_ffff_ffff, 64'd1, 0);
      issue_op(op_add, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0);
      issue_op(op_sub, 64'h8000_0000_0000_0000, 64'd1, 0);
      issue_op(op_sub, 64'h7fff_ffff_ffff_ffff, '1, 0);
      report_test("carry_edges");
   endtask

   task automatic logic_random();
      for (int i = 0; i < 30; i++) begin
         issue_op(pick_op(2 + $urandom_range(2, 0)), rand_word(), rand_word(), 0);
      end
      report_test("logic_random");
   endtask

   task automatic handshake_hold();
      for (int i = 0; i < 10; i++) begin
         issue_op(pick_op($urandom_range(4, 0)), rand_word(), rand_word(),
                  int'($urandom_range(8, 1)));
      end
      report_test("handshake_hold");
   endtask

   initial begin
      void'($urandom(seed));
      fails        = 0;
      ops          = 0;
      fails_before = 0;
      exp_result   = '0;
      exp_zero     = 1'b0;
      exp_negative = 1'b0;
      exp_carry    = 1'b0;
      exp_overflow = 1'b0;
      rst = 1'b1;
      req = 1'b0;
      op  = op_add;
      a   = '0;
      b   = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      add_random();
      sub_random();
      carry_edges();
      logic_random();
      handshake_hold();

      repeat (2) @(negedge clk);  // last checks settle.
      $display("tests 5, ops %0d, failures %0d", ops, fails);
      if (fails == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: compile.f
common/alu_pkg.sv
adder/sparse_carry_adder.sv
hw/logic_unit.sv
hw/result_merge.sv
hw/op_port_ctrl.sv
hw/alu_top.sv
bench/alu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   --top-module alu_tb \
   -f compile.f \
   -o alu_sim

./obj_dir/alu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
   echo "simulation reported failure"
   exit 1
fi
echo "simulation finished without failure"
